// File: filelist.f
verilog/cache_pkg.sv
verilog/way_ctrl_if.sv
verilog/onehot_to_bin.sv
verilog/policy_mem.sv
verilog/replacement_policy.sv
verilog/tag_array.sv
verilog/cache_tag_unit.sv
tb/cache_tag_unit_sva.sv
tb/cache_tag_unit_tb.sv

// File: Makefile
# Verilator flow for the cache tag unit testbench

VERILATOR  ?= verilator
TOP        ?= cache_tag_unit_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only if the pass message shows up as a line of its own
run: build
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/cache_tag_unit_tb.sv
`timescale 1ns/100ps

module cache_tag_unit_tb
   import cache_pkg::*;
();

   localparam int N_RANDOM   = 400;                           // cycles of random traffic
   localparam int N_DIRECTED = 60;                            // upper bound of the directed part
   localparam int TIMEOUT_NS = (N_DIRECTED + N_RANDOM) * 4 + 200;

   logic              clk = 1'b0;
   logic              rst_n;
   logic              req;
   logic [ADDR_W-1:0] addr;
   logic              resp_valid;
   logic              hit;
   logic [NWAY_W-1:0] way;

   int seed   = 31905;
   int errors = 0;                                            // model mismatches

   // reference model, m_order[s][0] is the least recently used way of set s
   logic [TAG_W-1:0]  m_tag   [N_SETS][N_WAYS];
   logic [N_WAYS-1:0] m_valid [N_SETS];
   int                m_order [N_SETS][N_WAYS];
   logic              exp_valid;
   logic              exp_hit;
   logic [NWAY_W-1:0] exp_way;

   always #2 clk = ~clk;

   cache_tag_unit i_cache_tag_unit
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .addr       (addr),
      .resp_valid (resp_valid),
      .hit        (hit),
      .way        (way)
   );

   // the model sees the same edge values as the DUT and predicts the next response
   always @(posedge clk)
   begin
      int s;
      int w;
      int p;
      logic [TAG_W-1:0] t;
      if (!rst_n)
      begin
         for (int i = 0; i < N_SETS; i++)
         begin
            m_valid[i] = '0;
            for (int k = 0; k < N_WAYS; k++)
               m_order[i][k] = k;                            // an empty set fills way 0 first
         end
         exp_valid <= 1'b0;
         exp_hit   <= 1'b0;
      end
      else
      begin
         exp_valid <= req;
         exp_hit   <= 1'b0;
         if (req)
         begin
            s = int'(addr[SET_W-1:0]);
            t = addr[ADDR_W-1 -: TAG_W];
            w = -1;
            for (int k = 0; k < N_WAYS; k++)
               if (m_valid[s][k] && m_tag[s][k] == t)
                  w = k;
            exp_hit <= (w >= 0);
            if (w < 0)
            begin
               w = m_order[s][0];                             // oldest way makes room
               m_tag[s][w]   = t;
               m_valid[s][w] = 1'b1;
            end
            exp_way <= NWAY_W'(w);
            p = 0;
            for (int k = 0; k < N_WAYS; k++)
               if (m_order[s][k] == w)
                  p = k;
            for (int k = p; k < N_WAYS - 1; k++)
               m_order[s][k] = m_order[s][k+1];               // everything newer moves down one
            m_order[s][N_WAYS-1] = w;                         // used way is now the newest
         end
      end
   end

   a_valid_check: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid == exp_valid)
   else
   begin
      errors++;
      $display("CHECK FAILED at %0t: resp_valid is %b, model expects %b",
               $time, $sampled(resp_valid), $sampled(exp_valid));
   end

   a_hit_check: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid |-> (hit == exp_hit))
   else
   begin
      errors++;
      $display("CHECK FAILED at %0t: hit is %b, model expects %b",
               $time, $sampled(hit), $sampled(exp_hit));
   end

   a_way_check: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid |-> (way == exp_way))
   else
   begin
      errors++;
      $display("CHECK FAILED at %0t: way is %0d, model expects %0d",
               $time, $sampled(way), $sampled(exp_way));
   end

   task automatic drive_access(input logic [TAG_W-1:0] tag, input logic [SET_W-1:0] set);
      @(posedge clk);
      req  <= 1'b1;
      addr <= {tag, set};
   endtask

   task automatic drive_idle(input int cycles);
      repeat (cycles)
      begin
         @(posedge clk);
         req <= 1'b0;
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      req   <= 1'b0;
      rst_n <= 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   task automatic drive_random(input int cycles);
      logic [31:0] r;
      repeat (cycles)
      begin
         r = $random(seed);
         @(posedge clk);
         req  <= (r[1:0] != 2'b00);                           // about one cycle in four is idle
         addr <= {TAG_W'(8'h30 + r[15:8] % 8'd6), SET_W'(r[17:16])};  // 6 tags over 4 sets
      end
   endtask

   initial
   begin
      rst_n = 1'b0;
      req   = 1'b0;
      addr  = '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      // four tags fill set 3 in way order
      drive_access(8'hA0, 3'd3);
      drive_access(8'hA1, 3'd3);
      drive_access(8'hA2, 3'd3);
      drive_access(8'hA3, 3'd3);
      // miss then hit right behind it
      drive_access(8'h11, 3'd5);
      drive_access(8'h11, 3'd5);
      drive_idle(1);
      // hits on A0 and A2 leave A1 as the oldest, A4 evicts it
      drive_access(8'hA0, 3'd3);
      drive_access(8'hA2, 3'd3);
      drive_access(8'hA4, 3'd3);
      drive_access(8'hA1, 3'd3);                              // evicted tag misses again
      // traffic in set 6 must not touch set 3
      drive_access(8'hB0, 3'd6);
      drive_access(8'hB1, 3'd6);
      drive_access(8'hA0, 3'd3);
      drive_access(8'hA4, 3'd3);
      // an address that hits before reset misses after it
      drive_access(8'h42, 3'd1);
      drive_access(8'h42, 3'd1);
      drive_idle(2);
      apply_reset();
      drive_access(8'h42, 3'd1);
      drive_idle(2);
      drive_random(N_RANDOM);
      drive_idle(3);
      $display("errors: %0d model check(s), %0d protocol assertion(s)",
               errors, i_cache_tag_unit.i_cache_tag_unit_sva.fail_count);
      if (errors == 0 && i_cache_tag_unit.i_cache_tag_unit_sva.fail_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // stops a run that never reaches the end of its stimulus
   initial
   begin
      #(TIMEOUT_NS);
      $display("timeout: stimulus did not finish within %0d ns", TIMEOUT_NS);
      $display("errors: %0d model check(s)", errors);
      $display("Test failed");
      $finish;
   end

endmodule

// File: tb/cache_tag_unit_sva.sv
`timescale 1ns/100ps

// response protocol checks of the tag unit that bind into the top level
module cache_tag_unit_sva
   import cache_pkg::*;
(
   input logic              clk,
   input logic              rst_n,
   input logic              req,
   input logic              resp_valid,
   input logic              hit,
   input logic [NWAY_W-1:0] way
);

   int fail_count = 0;                    // protocol assertions that have failed so far

   // every request is answered exactly one cycle later
   a_req_resp: assert property (@(posedge clk) disable iff (!rst_n)
      req |=> resp_valid)
   else
   begin
      fail_count++;
      $error("request was not answered in the next cycle");
   end

   // and nothing is answered that was not asked for
   a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
      !req |=> !resp_valid)
   else
   begin
      fail_count++;
      $error("resp_valid raised without a request in the cycle before");
   end

   a_hit_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !resp_valid |-> !hit)
   else
   begin
      fail_count++;
      $error("hit is high while resp_valid is low");
   end

   a_way_known: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid |-> !$isunknown(way))
   else
   begin
      fail_count++;
      $error("way is unknown during a response");
   end

endmodule

bind cache_tag_unit cache_tag_unit_sva i_cache_tag_unit_sva
(
   .clk        (clk),
   .rst_n      (rst_n),
   .req        (req),
   .resp_valid (resp_valid),
   .hit        (hit),
   .way        (way)
);

// File: verilog/cache_tag_unit.sv
`timescale 1ns/100ps

// tag side of a set-associative cache, a miss is filled in the same cycle
module cache_tag_unit
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req,          // access strobe, may be high every cycle
   input  logic [ADDR_W-1:0] addr,
   output logic              resp_valid,   // follows req by one cycle
   output logic              hit,
   output logic [NWAY_W-1:0] way
);

   // set, used way and victim between the two halves
   way_ctrl_if i_way_ctrl ();

   // lookup, fill and response
   tag_array i_tag_array
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .addr       (addr),
      .resp_valid (resp_valid),
      .hit        (hit),
      .way        (way),
      .ctrl       (i_way_ctrl.tag)
   );

   // picks the victim and tracks recency per set
   replacement_policy #(
      .POLICY (REP_POLICY)
   ) i_replacement_policy
   (
      .clk   (clk),
      .rst_n (rst_n),
      .ctrl  (i_way_ctrl.policy)
   );

endmodule

// File: verilog/tag_array.sv
`timescale 1ns/100ps

// tags and valid bits of every way, the parallel compare and the response register
module tag_array
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req,          // one-cycle access strobe
   input  logic [ADDR_W-1:0] addr,         // {tag, set}
   output logic              resp_valid,   // one cycle after req
   output logic              hit,
   output logic [NWAY_W-1:0] way,          // hit way, or the way just filled
   way_ctrl_if.tag           ctrl
);

   logic [TAG_W-1:0]  tag_mem [N_SETS][N_WAYS];
   logic [N_WAYS-1:0] valid   [N_SETS];
   logic [TAG_W-1:0]  req_tag;
   logic [SET_W-1:0]  req_set;
   logic [N_WAYS-1:0] match;               // one-hot, tags never repeat inside a set
   logic              hit_any;
   logic [N_WAYS-1:0] used_way;            // matched way on a hit, victim on a miss
   logic [NWAY_W-1:0] used_way_bin;

   assign req_tag = addr[ADDR_W-1 -: TAG_W];
   assign req_set = addr[SET_W-1:0];

   // compare against every way of the set at once
   always_comb
   begin
      for (int w = 0; w < N_WAYS; w++)
         match[w] = valid[req_set][w] && (tag_mem[req_set][w] == req_tag);
   end

   assign hit_any  = |match;
   assign used_way = hit_any ? match : ctrl.way_select;

   onehot_to_bin i_way_bin
   (
      .onehot (used_way),
      .bin    (used_way_bin)
   );

   // the policy moves on every access, hit or fill
   assign ctrl.set     = req_set;
   assign ctrl.way_hit = used_way;
   assign ctrl.update  = req;

   // a miss is filled at once into the victim, so the next access already hits
   always_ff @(posedge clk)
   begin
      if (req && !hit_any)
         tag_mem[req_set][ctrl.way_select_bin] <= req_tag;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int s = 0; s < N_SETS; s++)
            valid[s] <= '0;
      end
      else if (req && !hit_any)
      begin
         valid[req_set][ctrl.way_select_bin] <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         resp_valid <= 1'b0;
         hit        <= 1'b0;
      end
      else
      begin
         resp_valid <= req;
         hit        <= req && hit_any;     // low between responses
      end
   end

   // way only means something while resp_valid is high
   always_ff @(posedge clk)
   begin
      if (req)
         way <= used_way_bin;
   end

endmodule

// File: verilog/replacement_policy.sv
`timescale 1ns/100ps

// per-set replacement state with its update rule and victim decoder
module replacement_policy
   import cache_pkg::*;
#(
   parameter rep_policy_e POLICY = POLICY_LRU  // which of the three policies is built
)
(
   input  logic       clk,
   input  logic       rst_n,
   way_ctrl_if.policy ctrl
);

   logic [POLICY_STATE_W-1:0] state_rd;        // stored state of ctrl.set
   logic [POLICY_STATE_W-1:0] state_wd;        // state after the use named by way_hit
   logic [N_WAYS-1:0]         way_sel;         // one-hot victim of ctrl.set

   policy_mem i_policy_mem
   (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (ctrl.update),
      .set   (ctrl.set),
      .wdata (state_wd),
      .rdata (state_rd)
   );

   generate
      if (POLICY == POLICY_LRU)
      begin : g_lru
         // each way has a counter where 0 is least recently used and the maximum is most recent
         logic [NWAY_W-1:0] lru_cnt [N_WAYS];
         logic [NWAY_W-1:0] used_cnt;           // old counter of the used way

         always_comb
         begin
            used_cnt = '0;
            state_wd = '0;
            // an all-zero word only happens after reset and stands for way i at i
            for (int i = 0; i < N_WAYS; i++)
            begin
               if (|state_rd[LRU_STATE_W-1:0])
                  lru_cnt[i] = state_rd[i*NWAY_W +: NWAY_W];
               else
                  lru_cnt[i] = NWAY_W'(i);
            end
            // pick the used counter out with an OR since way_hit is one-hot
            for (int i = 0; i < N_WAYS; i++)
            begin
               if (ctrl.way_hit[i])
                  used_cnt = used_cnt | lru_cnt[i];
            end
            for (int i = 0; i < N_WAYS; i++)
            begin
               if (ctrl.way_hit[i])
                  state_wd[i*NWAY_W +: NWAY_W] = '1;                 // used way becomes newest
               else if (lru_cnt[i] > used_cnt)
                  state_wd[i*NWAY_W +: NWAY_W] = lru_cnt[i] - 1'b1;  // closes the gap it left
               else
                  state_wd[i*NWAY_W +: NWAY_W] = lru_cnt[i];
               way_sel[i] = (lru_cnt[i] == '0);                     // oldest way is the victim
            end
         end
      end
      else if (POLICY == POLICY_PLRU_MRU)
      begin : g_plru_mru
         logic [MRU_STATE_W-1:0] mru_rd;        // one bit per way, set when used
         logic [MRU_STATE_W-1:0] mru_set;       // bits with the new use added

         assign mru_rd  = state_rd[MRU_STATE_W-1:0];
         assign mru_set = mru_rd | ctrl.way_hit;

         always_comb
         begin
            logic lower_used;                   // every way below the current one has its bit set
            state_wd = '0;
            // once every way has been used the history restarts from the used way
            if (&mru_set)
               state_wd[MRU_STATE_W-1:0] = ctrl.way_hit;
            else
               state_wd[MRU_STATE_W-1:0] = mru_set;
            // the victim is the lowest way with a clear bit and the word is never all ones
            lower_used = 1'b1;
            for (int i = 0; i < N_WAYS; i++)
            begin
               way_sel[i] = ~mru_rd[i] & lower_used;
               lower_used = lower_used & mru_rd[i];
            end
         end
      end
      else
      begin : g_plru_tree
         // node n of the tree (root is 1, children 2n and 2n+1) lives in bit n-1
         // a node bit of 1 points at the upper half, where the next victim is
         logic [TREE_STATE_W-1:0] tree_rd;

         assign tree_rd = state_rd[TREE_STATE_W-1:0];

         always_comb
         begin
            int node;                           // walks from the root down to a leaf
            state_wd = '0;
            state_wd[TREE_STATE_W-1:0] = tree_rd;
            // every node on the path of the used way turns to the other half
            for (int w = 0; w < N_WAYS; w++)
            begin
               if (ctrl.way_hit[w])
               begin
                  for (int l = 0; l < NWAY_W; l++)
                     state_wd[(1 << l) + (w >> (NWAY_W - l)) - 1] =
                        (((w >> (NWAY_W - 1 - l)) & 1) == 0);
               end
            end
            node = 1;
            for (int l = 0; l < NWAY_W; l++)
               node = 2 * node + int'(tree_rd[node-1]);   // follow the pointer down
            for (int w = 0; w < N_WAYS; w++)
               way_sel[w] = (node == N_WAYS + w);          // leaves are N_WAYS + way
         end
      end
   endgenerate

   assign ctrl.way_select = way_sel;

   // the victim number is what the tag array uses as its write way
   onehot_to_bin i_victim_bin
   (
      .onehot (way_sel),
      .bin    (ctrl.way_select_bin)
   );

endmodule

// File: verilog/policy_mem.sv
`timescale 1ns/100ps

// per-set replacement state, one word per set
module policy_mem
   import cache_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,   // clears every word
   input  logic                      en,      // write wdata into the word of set
   input  logic [SET_W-1:0]          set,     // read and write share the index
   input  logic [POLICY_STATE_W-1:0] wdata,
   output logic [POLICY_STATE_W-1:0] rdata
);

   logic [POLICY_STATE_W-1:0] mem [N_SETS];

   // a zero word is what every policy reads as its starting order
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int s = 0; s < N_SETS; s++)
            mem[s] <= '0;
      end
      else if (en)
      begin
         mem[set] <= wdata;             // new state is seen by the access one cycle later
      end
   end

   // asynchronous read so the victim is known in the cycle of the request
   assign rdata = mem[set];

endmodule

// File: verilog/onehot_to_bin.sv
`timescale 1ns/100ps

// turns a one-hot way vector into a way number
module onehot_to_bin
   import cache_pkg::*;
(
   input  logic [N_WAYS-1:0] onehot,    // at most one bit set
   output logic [NWAY_W-1:0] bin        // number of the set bit, zero when none
);

   // each output bit is the OR of the one-hot bits whose index has that bit set
   // so no priority chain is needed as long as the input really is one-hot
   always_comb
   begin
      bin = '0;
      for (int i = 0; i < N_WAYS; i++)
      begin
         if (onehot[i])
            bin = bin | NWAY_W'(i);     // only one term ever contributes
      end
   end

endmodule

// File: verilog/way_ctrl_if.sv
`timescale 1ns/100ps

// link between the tag array and the replacement block
interface way_ctrl_if
   import cache_pkg::*;
();

   logic [SET_W-1:0]  set;              // set of the current access
   logic [N_WAYS-1:0] way_hit;          // one-hot, the way just used (hit or filled)
   logic              update;           // move the policy state of set on the next edge
   logic [N_WAYS-1:0] way_select;       // one-hot victim of set
   logic [NWAY_W-1:0] way_select_bin;   // same victim as a way number

   // the tag array says what was used
   modport tag (output set, way_hit, update, input way_select, way_select_bin);

   // the replacement block answers with the victim
   modport policy (input set, way_hit, update, output way_select, way_select_bin);

endinterface

// File: verilog/cache_pkg.sv
package cache_pkg;

   // cache geometry, the tag side only
   localparam int N_WAYS = 4;                   // ways per set
   localparam int NWAY_W = $clog2(N_WAYS);      // bits needed to number a way
   localparam int SET_W  = 3;                   // set index width
   localparam int N_SETS = 1 << SET_W;          // 8 sets
   localparam int TAG_W  = 8;                   // tag width
   localparam int ADDR_W = TAG_W + SET_W;       // request address is {tag, set}

   // replacement policies the replacement block can be built with
   typedef enum logic [1:0]
   {
      POLICY_LRU,                               // true LRU, one counter per way
      POLICY_PLRU_MRU,                          // one MRU bit per way
      POLICY_PLRU_TREE                          // binary tree of direction bits
   } rep_policy_e;

   // the policy the top level builds
   localparam rep_policy_e REP_POLICY = POLICY_LRU;

   // per-set state widths of each policy
   localparam int LRU_STATE_W  = N_WAYS * NWAY_W;   // a counter per way
   localparam int MRU_STATE_W  = N_WAYS;            // a bit per way
   localparam int TREE_STATE_W = N_WAYS - 1;        // one bit per inner tree node

   // the policy memory is sized for the widest policy, so a word fits any of them
   localparam int POLICY_STATE_W =
      (LRU_STATE_W > MRU_STATE_W) ?
         ((LRU_STATE_W > TREE_STATE_W) ? LRU_STATE_W : TREE_STATE_W) :
         ((MRU_STATE_W > TREE_STATE_W) ? MRU_STATE_W : TREE_STATE_W);

endpackage
